/* src/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address split into 16 lines of 8 bytes
`define DCACHE_ADDR_BITS 32
`define DCACHE_OFFSET_BITS 3
`define DCACHE_INDEX_BITS 4
`define DCACHE_TAG_BITS (`DCACHE_ADDR_BITS - `DCACHE_INDEX_BITS - `DCACHE_OFFSET_BITS)
`define DCACHE_LINES (1 << `DCACHE_INDEX_BITS)

// merge queue of the miss entry
`define DCACHE_Q_DEPTH 4

// zero as a memory transaction tag means no transaction
`define MEM_TAG_BITS 4

`endif

/* src/mem_pkg.sv */
`include "dcache_cfg.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_LOAD  = 2'b01,
        MEM_STORE = 2'b10
    } mem_command_t;

    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    // one 64-bit block picked apart by byte, half or word
    typedef union packed {
        logic [7:0][7:0]  byte_level;
        logic [3:0][15:0] half_level;
        logic [1:0][31:0] word_level;
    } mem_block_t;

    typedef struct packed {
        mem_command_t                 command;
        logic [`DCACHE_ADDR_BITS-1:0] addr;
        mem_block_t                   data;
    } mem_req_t;

endpackage

/* src/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_func_t;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  load_id_t;

    typedef struct packed {
        logic                         valid;
        logic                         is_store;
        mem_func_t                    func;
        logic [`DCACHE_ADDR_BITS-1:0] addr;
        word_t                        data;
        load_id_t                     load_id;
    } cache_req_t;

    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [`DCACHE_TAG_BITS-1:0] tag;
        mem_pkg::mem_block_t         block;
    } cache_line_t;

    // one request parked in the miss queue
    typedef struct packed {
        logic                           is_store;
        mem_func_t                      func;
        logic [`DCACHE_OFFSET_BITS-1:0] offset;
        word_t                          data;
        load_id_t                       load_id;
    } miss_rec_t;

    typedef struct packed {
        logic     valid;
        load_id_t load_id;
        word_t    data;
    } load_result_t;

endpackage

/* src/dcache_lookup.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_lookup (
    input  dcache_pkg::cache_req_t                         req,
    input  dcache_pkg::cache_line_t [`DCACHE_LINES-1:0]    lines,
    output logic                                           hit,
    output logic                                           miss,
    output logic [`DCACHE_INDEX_BITS-1:0]                  index,
    output logic [`DCACHE_TAG_BITS-1:0]                    tag,
    output logic [`DCACHE_OFFSET_BITS-1:0]                 offset
);

    localparam int INDEX_LO = `DCACHE_OFFSET_BITS;
    localparam int TAG_LO   = `DCACHE_OFFSET_BITS + `DCACHE_INDEX_BITS;

    // address fields
    assign offset = req.addr[`DCACHE_OFFSET_BITS-1:0];
    assign index  = req.addr[TAG_LO-1:INDEX_LO];
    assign tag    = req.addr[`DCACHE_ADDR_BITS-1:TAG_LO];

    // direct mapped so only one line to look at
    always_comb begin
        hit  = 1'b0;
        miss = 1'b0;
        if (req.valid) begin
            if (lines[index].valid && lines[index].tag == tag) begin
                hit = 1'b1;
            end else begin
                miss = 1'b1;
            end
        end
    end

endmodule

/* src/dcache_miss_entry.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_miss_entry (
    input  logic                                           clock,
    input  logic                                           reset,
    input  dcache_pkg::cache_req_t                         req,
    input  logic                                           miss,
    input  logic [`DCACHE_INDEX_BITS-1:0]                  index,
    input  logic [`DCACHE_TAG_BITS-1:0]                    tag,
    input  logic [`DCACHE_OFFSET_BITS-1:0]                 offset,
    input  logic                                           mem_grant,
    input  mem_pkg::mem_tag_t                              mem_response_tag,
    input  mem_pkg::mem_tag_t                              mem_data_tag,
    output logic                                           miss_accept,
    output logic                                           load_request,
    output logic [`DCACHE_ADDR_BITS-1:0]                   line_addr,
    output logic                                           fill,
    output dcache_pkg::miss_rec_t [`DCACHE_Q_DEPTH-1:0]    queue,
    output logic [`DCACHE_Q_DEPTH-1:0]                     queue_valid
);
    import mem_pkg::*;

    localparam int CNT_BITS = $clog2(`DCACHE_Q_DEPTH + 1);
    localparam int IDX_BITS = $clog2(`DCACHE_Q_DEPTH);

    typedef enum logic [1:0] {
        ENTRY_FREE,
        ENTRY_PENDING,
        ENTRY_WAIT
    } entry_state_t;

    entry_state_t                  state;
    logic [CNT_BITS-1:0]           count;
    logic [`DCACHE_TAG_BITS-1:0]   line_tag;
    logic [`DCACHE_INDEX_BITS-1:0] line_index;
    mem_tag_t                      mem_tag;
    logic                          line_match;

    assign line_match = (state != ENTRY_FREE) && line_tag == tag && line_index == index;

    // no merging in the fill cycle while the queue drains
    assign miss_accept = miss && !fill
                         && ((state == ENTRY_FREE)
                             || (line_match && count < CNT_BITS'(`DCACHE_Q_DEPTH)));

    assign load_request = (state == ENTRY_PENDING) && mem_grant;
    assign fill         = (state == ENTRY_WAIT) && mem_data_tag == mem_tag;
    assign line_addr    = {line_tag, line_index, {`DCACHE_OFFSET_BITS{1'b0}}};

    always_comb begin
        for (int i = 0; i < `DCACHE_Q_DEPTH; i++) begin
            queue_valid[i] = CNT_BITS'(i) < count;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ENTRY_FREE;
            count <= '0;
        end else begin
            case (state)
                ENTRY_FREE: begin
                    if (miss_accept) begin
                        state <= ENTRY_PENDING;
                    end
                end
                ENTRY_PENDING: begin
                    // nonzero tag means memory took the load
                    if (load_request && mem_response_tag != '0) begin
                        state <= ENTRY_WAIT;
                    end
                end
                default: begin
                    if (fill) begin
                        state <= ENTRY_FREE;
                    end
                end
            endcase
            if (fill) begin
                count <= '0;
            end else if (miss_accept) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == ENTRY_FREE && miss_accept) begin
            line_tag   <= tag;
            line_index <= index;
        end
        if (load_request && mem_response_tag != '0) begin
            mem_tag <= mem_response_tag;
        end
        if (miss_accept) begin
            queue[count[IDX_BITS-1:0]] <= '{req.is_store, req.func, offset, req.data, req.load_id};
        end
    end

endmodule

/* src/dcache_line_array.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_line_array (
    input  logic                                           clock,
    input  logic                                           reset,
    input  dcache_pkg::cache_req_t                         req,
    input  logic                                           hit,
    input  logic [`DCACHE_INDEX_BITS-1:0]                  index,
    input  logic [`DCACHE_TAG_BITS-1:0]                    tag,
    input  logic [`DCACHE_OFFSET_BITS-1:0]                 offset,
    input  logic                                           fill,
    input  logic [`DCACHE_INDEX_BITS-1:0]                  fill_index,
    input  logic [`DCACHE_TAG_BITS-1:0]                    fill_tag,
    input  dcache_pkg::miss_rec_t [`DCACHE_Q_DEPTH-1:0]    queue,
    input  logic [`DCACHE_Q_DEPTH-1:0]                     queue_valid,
    input  mem_pkg::mem_block_t                            mem_data,
    output dcache_pkg::cache_line_t [`DCACHE_LINES-1:0]    lines,
    output dcache_pkg::load_result_t                       hit_result,
    output dcache_pkg::load_result_t [`DCACHE_Q_DEPTH-1:0] fill_results,
    output logic                                           victim_write,
    output mem_pkg::mem_req_t                              victim_req
);
    import mem_pkg::*;
    import dcache_pkg::*;

    logic [`DCACHE_LINES-1:0]    valid_q;
    logic [`DCACHE_LINES-1:0]    dirty_q;
    logic [`DCACHE_TAG_BITS-1:0] tag_q   [`DCACHE_LINES];
    mem_block_t                  block_q [`DCACHE_LINES];
    mem_block_t                  fill_block;
    logic                        fill_dirty;

    function automatic mem_block_t merge_store(input mem_block_t blk, input mem_func_t func,
                                               input logic [`DCACHE_OFFSET_BITS-1:0] off,
                                               input word_t data);
        mem_block_t res;
        res = blk;
        case (func)
            MEM_BYTE: res.byte_level[off] = data[7:0];
            MEM_HALF: res.half_level[off[`DCACHE_OFFSET_BITS-1:1]] = data[15:0];
            default:  res.word_level[off[`DCACHE_OFFSET_BITS-1]] = data;
        endcase
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            lines[i] = '{valid_q[i], dirty_q[i], tag_q[i], block_q[i]};
        end
    end

    // hit load answered straight from the array
    assign hit_result = '{hit && !req.is_store, req.load_id,
                          block_q[index].word_level[offset[`DCACHE_OFFSET_BITS-1]]};

    // replay the queue over the new block in arrival order
    always_comb begin
        fill_block   = mem_data;
        fill_dirty   = 1'b0;
        fill_results = '0;
        for (int i = 0; i < `DCACHE_Q_DEPTH; i++) begin
            if (queue_valid[i]) begin
                if (queue[i].is_store) begin
                    fill_block = merge_store(fill_block, queue[i].func, queue[i].offset,
                                             queue[i].data);
                    fill_dirty = 1'b1;
                end else begin
                    fill_results[i] = '{fill, queue[i].load_id,
                        fill_block.word_level[queue[i].offset[`DCACHE_OFFSET_BITS-1]]};
                end
            end
        end
    end

    // dirty victim goes back to its old address
    assign victim_write = fill && valid_q[fill_index] && dirty_q[fill_index];
    assign victim_req   = victim_write
        ? '{MEM_STORE, {tag_q[fill_index], fill_index, {`DCACHE_OFFSET_BITS{1'b0}}},
            block_q[fill_index]}
        : '{MEM_NONE, '0, '0};

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill) begin
                valid_q[fill_index] <= 1'b1;
                dirty_q[fill_index] <= fill_dirty;
            end
            if (hit && req.is_store) begin
                dirty_q[index] <= 1'b1;
            end
        end
    end

    // top keeps a hit off the fill index during fill
    always_ff @(posedge clock) begin
        if (fill) begin
            tag_q[fill_index]   <= fill_tag;
            block_q[fill_index] <= fill_block;
        end
        if (hit && req.is_store) begin
            tag_q[index]   <= tag;
            block_q[index] <= merge_store(block_q[index], req.func, offset, req.data);
        end
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                                           clock,
    input  logic                                           reset,
    input  dcache_pkg::cache_req_t                         req,
    input  mem_pkg::mem_tag_t                              mem_response_tag,
    input  mem_pkg::mem_tag_t                              mem_data_tag,
    input  mem_pkg::mem_block_t                            mem_data,
    output logic                                           accept,
    output dcache_pkg::load_result_t                       hit_result,
    output dcache_pkg::load_result_t [`DCACHE_Q_DEPTH-1:0] fill_results,
    output mem_pkg::mem_req_t                              mem_req
);
    import mem_pkg::*;
    import dcache_pkg::*;

    localparam int TAG_LO = `DCACHE_OFFSET_BITS + `DCACHE_INDEX_BITS;

    cache_line_t [`DCACHE_LINES-1:0] lines;
    miss_rec_t [`DCACHE_Q_DEPTH-1:0] queue;
    logic [`DCACHE_Q_DEPTH-1:0]      queue_valid;
    logic                            hit;
    logic                            hit_ok;
    logic                            miss;
    logic                            miss_accept;
    logic                            load_request;
    logic                            fill;
    logic                            victim_write;
    mem_req_t                        victim_req;
    logic [`DCACHE_INDEX_BITS-1:0]   index;
    logic [`DCACHE_TAG_BITS-1:0]     tag;
    logic [`DCACHE_OFFSET_BITS-1:0]  offset;
    logic [`DCACHE_ADDR_BITS-1:0]    line_addr;
    logic [`DCACHE_INDEX_BITS-1:0]   fill_index;
    logic [`DCACHE_TAG_BITS-1:0]     fill_tag;

    assign fill_index = line_addr[TAG_LO-1:`DCACHE_OFFSET_BITS];
    assign fill_tag   = line_addr[`DCACHE_ADDR_BITS-1:TAG_LO];

    // the line being replaced is off limits in the fill cycle
    assign hit_ok = hit && !(fill && index == fill_index);
    assign accept = hit_ok || miss_accept;

    dcache_lookup i_lookup (
        .req(req), .lines(lines), .hit(hit), .miss(miss),
        .index(index), .tag(tag), .offset(offset)
    );

    dcache_miss_entry i_miss_entry (
        .clock(clock), .reset(reset), .req(req), .miss(miss),
        .index(index), .tag(tag), .offset(offset),
        .mem_grant(!victim_write), .mem_response_tag(mem_response_tag),
        .mem_data_tag(mem_data_tag), .miss_accept(miss_accept),
        .load_request(load_request), .line_addr(line_addr), .fill(fill),
        .queue(queue), .queue_valid(queue_valid)
    );

    dcache_line_array i_line_array (
        .clock(clock), .reset(reset), .req(req), .hit(hit_ok),
        .index(index), .tag(tag), .offset(offset),
        .fill(fill), .fill_index(fill_index), .fill_tag(fill_tag),
        .queue(queue), .queue_valid(queue_valid), .mem_data(mem_data),
        .lines(lines), .hit_result(hit_result), .fill_results(fill_results),
        .victim_write(victim_write), .victim_req(victim_req)
    );

    // victim store wins the bus and the load waits
    always_comb begin
        if (victim_write) begin
            mem_req = victim_req;
        end else if (load_request) begin
            mem_req = '{MEM_LOAD, line_addr, '0};
        end else begin
            mem_req = '{MEM_NONE, '0, '0};
        end
    end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clock,
    output logic reset
);

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // held over the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        #2 reset = 1'b0;
    end

endmodule

/* verif/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;
    import mem_pkg::*;
    import dcache_pkg::*;

    localparam int CLOCK_PERIOD = 20;
    localparam int NUM_TESTS    = 6;
    localparam int WAIT_LIMIT   = 50;
    localparam int MEM_LATENCY  = 5;
    localparam int DRIVE_DELAY  = 2;

    logic                               clock;
    logic                               reset;
    cache_req_t                         req;
    mem_tag_t                           mem_response_tag;
    mem_tag_t                           mem_data_tag;
    mem_block_t                         mem_data;
    logic                               accept;
    load_result_t                       hit_result;
    load_result_t [`DCACHE_Q_DEPTH-1:0] fill_results;
    mem_req_t                           mem_req;

    // backing memory and the view a program expects
    logic [31:0] salt;
    logic [31:0] shadow_mem [logic [29:0]];
    logic [31:0] ref_mem    [logic [29:0]];
    mem_tag_t    next_tag;
    int          cycle_count;
    int          store_count;
    logic [31:0] last_store_addr;
    mem_tag_t    pend_tags  [$];
    logic [31:0] pend_addrs [$];
    int          pend_due   [$];

    // loads seen on fill_results in arrival order
    load_id_t fill_ids  [$];
    word_t    fill_data [$];

    tb_clock i_tb_clock (
        .clock(clock),
        .reset(reset)
    );

    dcache_top i_dcache_top (
        .clock(clock), .reset(reset), .req(req),
        .mem_response_tag(mem_response_tag), .mem_data_tag(mem_data_tag),
        .mem_data(mem_data), .accept(accept), .hit_result(hit_result),
        .fill_results(fill_results), .mem_req(mem_req)
    );

    // memory takes every load in the cycle it shows up
    assign mem_response_tag = (mem_req.command == MEM_LOAD) ? next_tag : '0;

    // initial contents mixed over the whole word address
    function automatic logic [31:0] pattern_word(input logic [29:0] waddr);
        return ({waddr, 2'b11} * 32'h9e3779b1) ^ salt;
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] addr);
        if (shadow_mem.exists(addr[31:2])) begin
            return shadow_mem[addr[31:2]];
        end
        return pattern_word(addr[31:2]);
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return pattern_word(addr[31:2]);
    endfunction

    // little endian with byte 0 in the low bits
    function automatic void ref_store(input mem_func_t func, input logic [31:0] addr,
                                      input word_t data);
        logic [31:0] word;
        word = ref_read(addr);
        case (func)
            MEM_BYTE: word[{addr[1:0], 3'b000} +: 8] = data[7:0];
            MEM_HALF: word[{addr[1], 4'b0000} +: 16] = data[15:0];
            default:  word = data;
        endcase
        ref_mem[addr[31:2]] = word;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    initial begin : memory_model
        logic        taken;
        logic [31:0] line;
        mem_data_tag = '0;
        mem_data     = '0;
        next_tag     = 4'd1;
        cycle_count  = 0;
        store_count  = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            taken = (mem_req.command == MEM_LOAD);
            if (taken) begin
                pend_tags.push_back(mem_response_tag);
                pend_addrs.push_back(mem_req.addr);
                pend_due.push_back(cycle_count + MEM_LATENCY);
            end
            if (mem_req.command == MEM_STORE) begin
                shadow_mem[mem_req.addr[31:2]]        = mem_req.data.word_level[0];
                shadow_mem[mem_req.addr[31:2] + 30'd1] = mem_req.data.word_level[1];
                store_count++;
                last_store_addr = mem_req.addr;
            end
            #DRIVE_DELAY;
            if (taken) begin
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            mem_data_tag = '0;
            mem_data     = '0;
            if (pend_due.size() != 0 && pend_due[0] == cycle_count) begin
                line         = pend_addrs.pop_front();
                mem_data_tag = pend_tags.pop_front();
                pend_due.delete(0);
                mem_data.word_level[0] = shadow_read(line);
                mem_data.word_level[1] = shadow_read(line + 32'd4);
            end
        end
    end

    // collect fill answers as they go by
    always @(negedge clock) begin
        for (int i = 0; i < `DCACHE_Q_DEPTH; i++) begin
            if (fill_results[i].valid) begin
                fill_ids.push_back(fill_results[i].load_id);
                fill_data.push_back(fill_results[i].data);
            end
        end
    end

    task automatic drive_request(input logic is_store, input mem_func_t func,
                                 input logic [31:0] addr, input word_t data,
                                 input load_id_t load_id);
        req.valid    = 1'b1;
        req.is_store = is_store;
        req.func     = func;
        req.addr     = addr;
        req.data     = data;
        req.load_id  = load_id;
    endtask

    // returns at the next drive point with the request dropped
    task automatic wait_accept(output load_result_t hit);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!accept) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("request was not accepted within the wait limit");
            end
            @(negedge clock);
            waited++;
        end
        hit = hit_result;
        @(posedge clock);
        #DRIVE_DELAY;
        req = '0;
    endtask

    task automatic wait_fill(input int count);
        int waited;
        waited = 0;
        while (fill_ids.size() < count) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("line fill did not return the queued loads in time");
            end
            @(posedge clock);
            #DRIVE_DELAY;
            waited++;
        end
    endtask

    task automatic issue_load(input logic [31:0] addr, input load_id_t load_id,
                              output load_result_t hit);
        drive_request(1'b0, MEM_WORD, addr, 32'h0, load_id);
        wait_accept(hit);
    endtask

    task automatic issue_store(input mem_func_t func, input logic [31:0] addr,
                               input word_t data);
        load_result_t hit;
        ref_store(func, addr, data);
        drive_request(1'b1, func, addr, data, 4'h0);
        wait_accept(hit);
        check_value("hit_result.valid", 64'(hit.valid), 64'(0));
    endtask

    task automatic clear_fills();
        fill_ids.delete();
        fill_data.delete();
    endtask

    task automatic test_reset_state();
        logic [`DCACHE_Q_DEPTH-1:0] fill_valid;
        @(negedge clock);
        for (int i = 0; i < `DCACHE_Q_DEPTH; i++) begin
            fill_valid[i] = fill_results[i].valid;
        end
        check_value("accept", 64'(accept), 64'(0));
        check_value("hit_result.valid", 64'(hit_result.valid), 64'(0));
        check_value("fill_results.valid", 64'(fill_valid), 64'(0));
        check_value("mem_req.command", 64'(mem_req.command), 64'(MEM_NONE));
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic test_load_miss_then_hit();
        load_result_t hit;
        logic [31:0]  expected;
        clear_fills();
        expected = ref_read(32'h0000_1008);
        issue_load(32'h0000_1008, 4'd1, hit);
        check_value("hit_result.valid", 64'(hit.valid), 64'(0));
        wait_fill(1);
        check_value("fill_results.load_id", 64'(fill_ids[0]), 64'(1));
        check_value("fill_results.data", 64'(fill_data[0]), 64'(expected));
        // now resident and answered in the same cycle
        issue_load(32'h0000_1008, 4'd2, hit);
        check_value("hit_result.valid", 64'(hit.valid), 64'(1));
        check_value("hit_result.load_id", 64'(hit.load_id), 64'(2));
        check_value("hit_result.data", 64'(hit.data), 64'(expected));
    endtask

    task automatic test_store_sizes();
        load_result_t hit;
        issue_store(MEM_BYTE, 32'h0000_1009, $urandom());
        issue_store(MEM_HALF, 32'h0000_100a, $urandom());
        issue_load(32'h0000_1008, 4'd3, hit);
        check_value("hit_result.valid", 64'(hit.valid), 64'(1));
        check_value("hit_result.data", 64'(hit.data), 64'(ref_read(32'h0000_1008)));
        issue_store(MEM_WORD, 32'h0000_100c, $urandom());
        issue_load(32'h0000_100c, 4'd4, hit);
        check_value("hit_result.valid", 64'(hit.valid), 64'(1));
        check_value("hit_result.data", 64'(hit.data), 64'(ref_read(32'h0000_100c)));
    endtask

    task automatic test_merged_misses();
        load_result_t hit;
        logic [31:0]  expected_low;
        clear_fills();
        expected_low = ref_read(32'h0000_2010);
        issue_load(32'h0000_2010, 4'd5, hit);
        issue_store(MEM_WORD, 32'h0000_2014, $urandom());
        // queued behind the store so it must see it
        issue_load(32'h0000_2014, 4'd6, hit);
        check_value("hit_result.valid", 64'(hit.valid), 64'(0));
        wait_fill(2);
        check_value("fill_results.load_id", 64'(fill_ids[0]), 64'(5));
        check_value("fill_results.data", 64'(fill_data[0]), 64'(expected_low));
        check_value("fill_results.load_id", 64'(fill_ids[1]), 64'(6));
        check_value("fill_results.data", 64'(fill_data[1]), 64'(ref_read(32'h0000_2014)));
    endtask

    task automatic test_busy_backpressure();
        load_result_t hit;
        logic [31:0]  expected_first;
        logic [31:0]  expected_second;
        clear_fills();
        expected_first  = ref_read(32'h0000_3018);
        expected_second = ref_read(32'h0000_3020);
        issue_load(32'h0000_3018, 4'd7, hit);
        drive_request(1'b0, MEM_WORD, 32'h0000_3020, 32'h0, 4'd8);
        @(negedge clock);
        check_value("accept", 64'(accept), 64'(0));
        wait_accept(hit);
        // only taken once the first line is in
        check_value("fill_results count", 64'(fill_ids.size()), 64'(1));
        wait_fill(2);
        check_value("fill_results.load_id", 64'(fill_ids[0]), 64'(7));
        check_value("fill_results.data", 64'(fill_data[0]), 64'(expected_first));
        check_value("fill_results.load_id", 64'(fill_ids[1]), 64'(8));
        check_value("fill_results.data", 64'(fill_data[1]), 64'(expected_second));
    endtask

    task automatic test_dirty_eviction();
        load_result_t hit;
        int           stores_before;
        clear_fills();
        issue_load(32'h0000_4028, 4'd9, hit);
        wait_fill(1);
        check_value("fill_results.data", 64'(fill_data[0]), 64'(ref_read(32'h0000_4028)));
        issue_store(MEM_WORD, 32'h0000_402c, $urandom());
        stores_before = store_count;
        // same index with another tag
        issue_load(32'h0000_50a8, 4'd10, hit);
        wait_fill(2);
        check_value("fill_results.data", 64'(fill_data[1]), 64'(ref_read(32'h0000_50a8)));
        check_value("victim store count", 64'(store_count), 64'(stores_before + 1));
        check_value("mem_req.addr", 64'(last_store_addr), 64'(32'h0000_4028));
        check_value("mem_req.data[31:0]", 64'(shadow_read(32'h0000_4028)),
                    64'(ref_read(32'h0000_4028)));
        check_value("mem_req.data[63:32]", 64'(shadow_read(32'h0000_402c)),
                    64'(ref_read(32'h0000_402c)));
        issue_load(32'h0000_402c, 4'd11, hit);
        wait_fill(3);
        check_value("fill_results.load_id", 64'(fill_ids[2]), 64'(11));
        check_value("fill_results.data", 64'(fill_data[2]), 64'(ref_read(32'h0000_402c)));
    endtask

    initial begin
        void'($urandom(32'h6d83a680));
        salt = $urandom();
        req  = '0;
        @(negedge reset);
        test_reset_state();
        test_load_miss_then_hit();
        test_store_sizes();
        test_merged_misses();
        test_busy_backpressure();
        test_dirty_eviction();
        $display("TESTBENCH PASSED");
        $finish;
    end

    // watchdog with a budget per test
    initial begin
        #(NUM_TESTS * 200 * CLOCK_PERIOD);
        abort_run("simulation ran out of time before the tests finished");
    end

endmodule

/* build.f */
+incdir+src
src/mem_pkg.sv
src/dcache_pkg.sv
src/dcache_lookup.sv
src/dcache_miss_entry.sv
src/dcache_line_array.sv
src/dcache_top.sv
verif/tb_clock.sv
verif/dcache_tb.sv

/* Makefile */
TOP     = dcache_tb
SOURCES = build.f $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

obj_dir/V$(TOP): $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f build.f

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f build.f
	verilator --lint-only --timescale 1ns/1ps --top-module dcache_top +incdir+src \
		src/mem_pkg.sv src/dcache_pkg.sv src/dcache_lookup.sv \
		src/dcache_miss_entry.sv src/dcache_line_array.sv src/dcache_top.sv

clean:
	rm -rf obj_dir
